/* source/qlayer_pkg.sv */
// Shared sizes and types for the qlayer output stage.
// Holds the datapath widths, the element and vector types and the buffer
// count type used by the MAC array, the vector buffer and the scalers.

package qlayer_pkg;

    // Number of parallel dot products and requantized outputs.
    localparam int NUM_ELEMENTS = 8;

    // Datapath widths.
    localparam int ACT_WIDTH = 8;
    localparam int WGT_WIDTH = 8;
    localparam int ACC_WIDTH = 20;
    localparam int OUT_WIDTH = 8;

    // Requantization parameters. Changing these changes the arithmetic.
    localparam int SCALE_BITS = 16;
    localparam int SHIFT_BITS = 4;

    // Configuration write pointer width, enough to address every element.
    localparam int ADDR_WIDTH = 3;

    // Number of vectors the buffer between MAC array and scalers can hold.
    localparam int BUF_DEPTH = 2;

    typedef logic signed [ACT_WIDTH-1:0]  act_t;
    typedef logic signed [WGT_WIDTH-1:0]  wgt_t;
    typedef logic signed [ACC_WIDTH-1:0]  acc_t;
    typedef logic signed [OUT_WIDTH-1:0]  out_t;
    typedef logic signed [SCALE_BITS-1:0] scale_t;
    typedef logic        [SHIFT_BITS-1:0] shift_t;

    typedef acc_t acc_vec_t [NUM_ELEMENTS];
    typedef out_t out_vec_t [NUM_ELEMENTS];
    typedef wgt_t wgt_vec_t [NUM_ELEMENTS];

    // Wide enough to hold every value from empty up to BUF_DEPTH.
    typedef logic [$clog2(BUF_DEPTH+1)-1:0] buf_cnt_t;

endpackage

/* source/scale_cfg_if.sv */
// Configuration write bus for the output scaler set.
// Carries the scale and shift write strobes with their data. Each strobe
// writes one element and advances that memory's own write pointer.
`timescale 1ns/1ps

interface scale_cfg_if;

    logic               scale_w_en;
    qlayer_pkg::scale_t scale_w_data;
    logic               shift_w_en;
    qlayer_pkg::shift_t shift_w_data;

    // Driven by the top level from its configuration ports.
    modport source (
        output scale_w_en, scale_w_data,
        output shift_w_en, shift_w_data
    );

    // Read by the scaler set, which owns the memories.
    modport sink (
        input scale_w_en, scale_w_data,
        input shift_w_en, shift_w_data
    );

endinterface

/* source/mac_array.sv */
// MAC array for the qlayer output stage.
// Multiplies one streamed activation per beat by a vector of weights and
// accumulates one dot product per element. On the last beat the finished
// vector is registered and pushed, and the accumulators restart from zero.
`timescale 1ns/1ps

module mac_array (
    input  logic                 clk,
    input  logic                 nrst,
    input  qlayer_pkg::act_t     x_i,
    input  qlayer_pkg::wgt_vec_t w_i,
    input  logic                 x_valid_i,
    input  logic                 x_last_i,
    output logic                 push_o,
    output qlayer_pkg::acc_vec_t wx_o
);

    // Running sums of the current beat stream.
    qlayer_pkg::acc_vec_t acc;

    // Sums including the product of the beat now on the inputs.
    qlayer_pkg::acc_vec_t acc_next;

    // The product is evaluated at the accumulator width, so the signed
    // operands are extended before the multiply and the sum simply wraps.
    always_comb begin
        for (int i = 0; i < qlayer_pkg::NUM_ELEMENTS; i++) begin
            acc_next[i] = acc[i] + x_i * w_i[i];
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < qlayer_pkg::NUM_ELEMENTS; i++) begin
                acc[i] <= '0;
            end
        end else if (x_valid_i) begin
            for (int i = 0; i < qlayer_pkg::NUM_ELEMENTS; i++) begin
                // A last beat closes the vector, so the next stream starts clean.
                if (x_last_i) begin
                    acc[i] <= '0;
                end else begin
                    acc[i] <= acc_next[i];
                end
            end
        end
    end

    // Finished vector register, loaded only when a stream ends.
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < qlayer_pkg::NUM_ELEMENTS; i++) begin
                wx_o[i] <= '0;
            end
        end else if (x_valid_i && x_last_i) begin
            for (int i = 0; i < qlayer_pkg::NUM_ELEMENTS; i++) begin
                wx_o[i] <= acc_next[i];
            end
        end
    end

    // The push strobe lines up with the vector it announces.
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            push_o <= 1'b0;
        end else begin
            push_o <= x_valid_i && x_last_i;
        end
    end

endmodule

/* source/wx_buffer.sv */
// Vector buffer between the MAC array and the output scalers.
// A small circular FIFO of accumulator vectors. A pop is taken whenever
// a read is requested and a vector is held; a push into a full buffer
// with no pop at the same edge is dropped and flagged until reset.
`timescale 1ns/1ps

module wx_buffer (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 push_i,
    input  qlayer_pkg::acc_vec_t wx_i,
    input  logic                 rd_i,
    output qlayer_pkg::acc_vec_t wx_o,
    output logic                 take_o,
    output logic                 avail_o,
    output logic                 overflow_o
);

    qlayer_pkg::acc_vec_t mem [qlayer_pkg::BUF_DEPTH];

    logic [$clog2(qlayer_pkg::BUF_DEPTH)-1:0] wr_ptr;
    logic [$clog2(qlayer_pkg::BUF_DEPTH)-1:0] rd_ptr;
    qlayer_pkg::buf_cnt_t                      count;
    logic                                      full;
    logic                                      do_push;

    assign avail_o = (count != '0);
    assign full    = (int'(count) == qlayer_pkg::BUF_DEPTH);
    assign take_o  = rd_i && avail_o;

    // A pop at the same edge frees a slot, so a full buffer still accepts.
    assign do_push = push_i && (!full || take_o);

    assign wx_o = mem[rd_ptr];

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < qlayer_pkg::BUF_DEPTH; i++) begin
                for (int j = 0; j < qlayer_pkg::NUM_ELEMENTS; j++) begin
                    mem[i][j] <= '0;
                end
            end
        end else if (do_push) begin
            mem[wr_ptr] <= wx_i;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= (int'(wr_ptr) == qlayer_pkg::BUF_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (take_o) begin
                rd_ptr <= (int'(rd_ptr) == qlayer_pkg::BUF_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !take_o) begin
                count <= count + 1'b1;
            end else if (take_o && !do_push) begin
                count <= count - 1'b1;
            end
            // The flag is sticky because the dropped vector is lost for good.
            if (push_i && !do_push) begin
                overflow_o <= 1'b1;
            end
        end
    end

endmodule

/* source/output_scaler.sv */
// Requantizer for one output element.
// Multiplies the accumulator by its scale at full width, adds the rounding
// term, shifts right arithmetically and saturates to the output width.
`timescale 1ns/1ps

module output_scaler #(
    parameter int INPUT_WIDTH  = qlayer_pkg::ACC_WIDTH,
    parameter int OUTPUT_WIDTH = qlayer_pkg::OUT_WIDTH,
    parameter int SCALE_BITS   = qlayer_pkg::SCALE_BITS,
    parameter int SHIFT_BITS   = qlayer_pkg::SHIFT_BITS
) (
    input  logic                           clk,
    input  logic                           nrst,
    input  logic signed [INPUT_WIDTH-1:0]  wx_i,
    input  logic signed [SCALE_BITS-1:0]   scale_i,
    input  logic        [SHIFT_BITS-1:0]   shift_i,
    input  logic                           en_i,
    output logic signed [OUTPUT_WIDTH-1:0] y_o
);

    logic signed [INPUT_WIDTH+SCALE_BITS-1:0] product;
    logic signed [INPUT_WIDTH+SCALE_BITS:0]   rounder;
    logic signed [INPUT_WIDTH+SCALE_BITS:0]   biased;
    logic signed [INPUT_WIDTH+SCALE_BITS:0]   shifted;
    logic                                     fits;
    logic signed [OUTPUT_WIDTH-1:0]           y_next;

    assign product = wx_i * scale_i;

    // Half an output LSB, so the shift rounds to nearest with ties upward.
    always_comb begin
        rounder = '0;
        if (shift_i != '0) begin
            rounder[shift_i - 1'b1] = 1'b1;
        end
    end

    // One spare bit keeps the rounding add from overflowing.
    assign biased  = product + rounder;
    assign shifted = biased >>> shift_i;

    // The value fits when every bit above the output sign bit matches it.
    assign fits = (&shifted[INPUT_WIDTH+SCALE_BITS:OUTPUT_WIDTH-1]) ||
                  !(|shifted[INPUT_WIDTH+SCALE_BITS:OUTPUT_WIDTH-1]);

    assign y_next = fits ? shifted[OUTPUT_WIDTH-1:0] :
                    shifted[INPUT_WIDTH+SCALE_BITS] ? {1'b1, {(OUTPUT_WIDTH-1){1'b0}}} :
                                                      {1'b0, {(OUTPUT_WIDTH-1){1'b1}}};

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            y_o <= '0;
        end else if (en_i) begin
            y_o <= y_next;
        end
    end

endmodule

/* source/output_scaler_set.sv */
// Output scaler set.
// Holds a scale and a shift per element, loaded one at a time through
// auto-incrementing write pointers, and requantizes a whole vector each
// time one is taken from the buffer.
`timescale 1ns/1ps

module output_scaler_set (
    input  logic                 clk,
    input  logic                 nrst,
    scale_cfg_if.sink            cfg,
    input  qlayer_pkg::acc_vec_t wx_i,
    input  logic                 take_i,
    output qlayer_pkg::out_vec_t y_o,
    output logic                 y_valid_o
);

    qlayer_pkg::scale_t output_scale [qlayer_pkg::NUM_ELEMENTS];
    qlayer_pkg::shift_t output_shift [qlayer_pkg::NUM_ELEMENTS];

    logic [qlayer_pkg::ADDR_WIDTH-1:0] scale_w_addr;
    logic [qlayer_pkg::ADDR_WIDTH-1:0] shift_w_addr;

    // Scales and shifts have separate pointers, so they can be loaded
    // in any interleaving. Both wrap after the last element.
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < qlayer_pkg::NUM_ELEMENTS; i++) begin
                output_scale[i] <= '0;
                output_shift[i] <= '0;
            end
            scale_w_addr <= '0;
            shift_w_addr <= '0;
        end else begin
            if (cfg.scale_w_en) begin
                output_scale[scale_w_addr] <= cfg.scale_w_data;
                scale_w_addr <= (int'(scale_w_addr) == qlayer_pkg::NUM_ELEMENTS - 1) ?
                                '0 : scale_w_addr + 1'b1;
            end
            if (cfg.shift_w_en) begin
                output_shift[shift_w_addr] <= cfg.shift_w_data;
                shift_w_addr <= (int'(shift_w_addr) == qlayer_pkg::NUM_ELEMENTS - 1) ?
                                '0 : shift_w_addr + 1'b1;
            end
        end
    end

    for (genvar i = 0; i < qlayer_pkg::NUM_ELEMENTS; i++) begin : g_scaler
        output_scaler #(
            .INPUT_WIDTH (qlayer_pkg::ACC_WIDTH),
            .OUTPUT_WIDTH(qlayer_pkg::OUT_WIDTH),
            .SCALE_BITS  (qlayer_pkg::SCALE_BITS),
            .SHIFT_BITS  (qlayer_pkg::SHIFT_BITS)
        ) u_output_scaler (
            .clk    (clk),
            .nrst   (nrst),
            .wx_i   (wx_i[i]),
            .scale_i(output_scale[i]),
            .shift_i(output_shift[i]),
            .en_i   (take_i),
            .y_o    (y_o[i])
        );
    end

    // The scalers register on the take, so valid is the take one cycle on.
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            y_valid_o <= 1'b0;
        end else begin
            y_valid_o <= take_i;
        end
    end

endmodule

/* source/qlayer_top.sv */
// Top level of the qlayer output stage.
// Connects the MAC array, the two-deep vector buffer and the output
// scaler set, and carries the configuration writes to the scalers.
`timescale 1ns/1ps

module qlayer_top (
    input  logic                 clk,
    input  logic                 nrst,

    // Activation stream and weights.
    input  qlayer_pkg::act_t     x_i,
    input  qlayer_pkg::wgt_vec_t w_i,
    input  logic                 x_valid_i,
    input  logic                 x_last_i,

    // Read request from downstream.
    input  logic                 rd_i,

    // Scale and shift configuration writes.
    input  logic                 scale_w_en_i,
    input  qlayer_pkg::scale_t   scale_w_data_i,
    input  logic                 shift_w_en_i,
    input  qlayer_pkg::shift_t   shift_w_data_i,

    output qlayer_pkg::out_vec_t y_o,
    output logic                 y_valid_o,
    output logic                 avail_o,
    output logic                 overflow_o
);

    logic                 push;
    qlayer_pkg::acc_vec_t mac_wx;
    qlayer_pkg::acc_vec_t head_wx;
    logic                 take;

    scale_cfg_if cfg_bus ();

    assign cfg_bus.scale_w_en   = scale_w_en_i;
    assign cfg_bus.scale_w_data = scale_w_data_i;
    assign cfg_bus.shift_w_en   = shift_w_en_i;
    assign cfg_bus.shift_w_data = shift_w_data_i;

    mac_array u_mac_array (
        .clk      (clk),
        .nrst     (nrst),
        .x_i      (x_i),
        .w_i      (w_i),
        .x_valid_i(x_valid_i),
        .x_last_i (x_last_i),
        .push_o   (push),
        .wx_o     (mac_wx)
    );

    wx_buffer u_wx_buffer (
        .clk       (clk),
        .nrst      (nrst),
        .push_i    (push),
        .wx_i      (mac_wx),
        .rd_i      (rd_i),
        .wx_o      (head_wx),
        .take_o    (take),
        .avail_o   (avail_o),
        .overflow_o(overflow_o)
    );

    output_scaler_set u_output_scaler_set (
        .clk      (clk),
        .nrst     (nrst),
        .cfg      (cfg_bus),
        .wx_i     (head_wx),
        .take_i   (take),
        .y_o      (y_o),
        .y_valid_o(y_valid_o)
    );

endmodule

/* verification/tb_clk_gen.sv */
// Clock and reset generator for the qlayer testbench.
// Makes a 10 ns clock and holds the active-low reset for ten cycles.
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic nrst_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // Reset is released just after an edge, like every other input.
    initial begin
        nrst_o = 1'b0;
        repeat (10) @(posedge clk_o);
        #1;
        nrst_o = 1'b1;
    end

endmodule

/* verification/qlayer_tb.sv */
// Testbench for the qlayer output stage.
// Drives beat streams and configuration writes into the top level and checks
// every requantized vector and the buffer flags against a reference model.
`timescale 1ns/1ps

module qlayer_tb;

    localparam int NE             = qlayer_pkg::NUM_ELEMENTS;
    localparam int VEC_BITS       = NE * qlayer_pkg::OUT_WIDTH;
    localparam int MAX_BEATS      = 16;
    localparam int TIMEOUT_CYCLES = 2000;

    logic                 clk;
    logic                 nrst;
    qlayer_pkg::act_t     x;
    qlayer_pkg::wgt_vec_t w;
    logic                 x_valid;
    logic                 x_last;
    logic                 rd;
    logic                 scale_w_en;
    qlayer_pkg::scale_t   scale_w_data;
    logic                 shift_w_en;
    qlayer_pkg::shift_t   shift_w_data;
    qlayer_pkg::out_vec_t y;
    logic                 y_valid;
    logic                 avail;
    logic                 overflow;

    // The model keeps the loaded configuration and the beats of the next stream.
    qlayer_pkg::scale_t   scale_cfg [NE];
    qlayer_pkg::shift_t   shift_cfg [NE];
    int                   scale_ptr;
    int                   shift_ptr;
    qlayer_pkg::act_t     beat_x [MAX_BEATS];
    qlayer_pkg::wgt_t     beat_w [MAX_BEATS][NE];
    logic [VEC_BITS-1:0]  exp_q [$];
    int                   n_pass;
    int                   n_fail;
    int                   cycles = 0;
    integer               seed;

    tb_clk_gen u_clk_gen (
        .clk_o (clk),
        .nrst_o(nrst)
    );

    qlayer_top dut0 (
        .clk           (clk),
        .nrst          (nrst),
        .x_i           (x),
        .w_i           (w),
        .x_valid_i     (x_valid),
        .x_last_i      (x_last),
        .rd_i          (rd),
        .scale_w_en_i  (scale_w_en),
        .scale_w_data_i(scale_w_data),
        .shift_w_en_i  (shift_w_en),
        .shift_w_data_i(shift_w_data),
        .y_o           (y),
        .y_valid_o     (y_valid),
        .avail_o       (avail),
        .overflow_o    (overflow)
    );

    // Dot product of one element over the stored beats, wrapped to the accumulator.
    function automatic qlayer_pkg::acc_t ref_dot(input int nbeats, input int e);
        int sum;
        sum = 0;
        for (int b = 0; b < nbeats; b++) begin
            sum += int'(beat_x[b]) * int'(beat_w[b][e]);
        end
        return qlayer_pkg::acc_t'(sum);
    endfunction

    // Requantizes with a full product, rounding half up, an arithmetic shift and saturation.
    function automatic qlayer_pkg::out_t ref_scale(input qlayer_pkg::acc_t wx,
                                                   input qlayer_pkg::scale_t s,
                                                   input qlayer_pkg::shift_t sh);
        longint prod;
        longint r;
        longint v;
        longint hi;
        hi   = (longint'(1) <<< (qlayer_pkg::OUT_WIDTH - 1)) - 1;
        prod = longint'(wx) * longint'(s);
        r    = (sh > 0) ? (longint'(1) <<< (sh - 1)) : longint'(0);
        v    = (prod + r) >>> sh;
        if (v > hi) begin
            v = hi;
        end else if (v < -hi - 1) begin
            v = -hi - 1;
        end
        return qlayer_pkg::out_t'(v);
    endfunction

    task automatic check_out(input string name, input qlayer_pkg::out_t exp,
                             input qlayer_pkg::out_t act);
        if (act !== exp) begin
            n_fail++;
            $display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end else begin
            n_pass++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            n_fail++;
            $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
        end else begin
            n_pass++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // One scale and one shift per call; the model pointers wrap like the DUT's.
    task automatic write_cfg(input qlayer_pkg::scale_t s, input qlayer_pkg::shift_t sh);
        next_cycle();
        scale_w_en   = 1'b1;
        scale_w_data = s;
        shift_w_en   = 1'b1;
        shift_w_data = sh;
        scale_cfg[scale_ptr] = s;
        shift_cfg[shift_ptr] = sh;
        scale_ptr = (scale_ptr + 1) % NE;
        shift_ptr = (shift_ptr + 1) % NE;
        next_cycle();
        scale_w_en = 1'b0;
        shift_w_en = 1'b0;
    endtask

    task automatic fill_random(input int nbeats);
        for (int b = 0; b < nbeats; b++) begin
            beat_x[b] = qlayer_pkg::act_t'($random(seed));
            for (int e = 0; e < NE; e++) begin
                beat_w[b][e] = qlayer_pkg::wgt_t'($random(seed));
            end
        end
    endtask

    // Streams the stored beats. A kept vector is expected back at the output.
    task automatic send_stream(input int nbeats, input bit keep);
        logic [VEC_BITS-1:0] exp_vec;
        for (int e = 0; e < NE; e++) begin
            exp_vec[e*qlayer_pkg::OUT_WIDTH +: qlayer_pkg::OUT_WIDTH] =
                ref_scale(ref_dot(nbeats, e), scale_cfg[e], shift_cfg[e]);
        end
        if (keep) begin
            exp_q.push_back(exp_vec);
        end
        for (int b = 0; b < nbeats; b++) begin
            next_cycle();
            x = beat_x[b];
            for (int e = 0; e < NE; e++) begin
                w[e] = beat_w[b][e];
            end
            x_valid = 1'b1;
            x_last  = (b == nbeats - 1);
        end
        next_cycle();
        x_valid = 1'b0;
        x_last  = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        next_cycle();
    endtask

    task automatic end_test(input string name, input int fails_at);
        $display("%s: %s", name, (n_fail == fails_at) ? "passed" : "failed");
    endtask

    // Outputs settle after the rising edge, so they are compared at the falling one.
    always @(negedge clk) begin : compare
        logic [VEC_BITS-1:0] exp_vec;
        if (nrst && y_valid) begin
            if (exp_q.size() == 0) begin
                n_fail++;
                $display("ERROR at %0t: y_valid_o rose with no vector expected", $time);
            end else begin
                exp_vec = exp_q.pop_front();
                for (int e = 0; e < NE; e++) begin
                    check_out($sformatf("y_o[%0d]", e),
                              exp_vec[e*qlayer_pkg::OUT_WIDTH +: qlayer_pkg::OUT_WIDTH], y[e]);
                end
            end
        end
    end

    // Generous margin over the total length of all tests.
    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("ERROR: run stopped after %0d cycles, outputs never arrived", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        int fails_at;
        int e;
        seed         = 32'h591c;
        x            = '0;
        x_valid      = 1'b0;
        x_last       = 1'b0;
        rd           = 1'b0;
        scale_w_en   = 1'b0;
        scale_w_data = '0;
        shift_w_en   = 1'b0;
        shift_w_data = '0;
        n_pass       = 0;
        n_fail       = 0;
        scale_ptr    = 0;
        shift_ptr    = 0;
        for (int i = 0; i < NE; i++) begin
            w[i]         = '0;
            scale_cfg[i] = '0;
            shift_cfg[i] = '0;
        end
        @(posedge nrst);
        next_cycle();

        // Unconfigured scales are zero, so the first vector reads back as zeros.
        fails_at = n_fail;
        @(negedge clk);
        check_flag("avail_o", 1'b0, avail);
        check_flag("y_valid_o", 1'b0, y_valid);
        check_flag("overflow_o", 1'b0, overflow);
        next_cycle();
        rd = 1'b1;
        fill_random(3);
        send_stream(3, 1'b1);
        wait_drain();
        end_test("reset state", fails_at);

        // Ten writes, so elements 0 and 1 are overwritten after the wrap.
        fails_at = n_fail;
        for (int k = 0; k < NE + 2; k++) begin
            write_cfg(qlayer_pkg::scale_t'($random(seed) % 256),
                      qlayer_pkg::shift_t'(8 + ($random(seed) & 7)));
        end
        repeat (6) begin
            fill_random(1);
            send_stream(1, 1'b1);
        end
        wait_drain();
        end_test("configuration and scaling", fails_at);

        // Elements 0 to 3 get huge products and clamp; 4 to 7 stay small and round.
        fails_at = n_fail;
        for (int k = 0; k < NE; k++) begin
            e = scale_ptr;
            if (e < 4) begin
                write_cfg((e % 2) ? 16'sh8000 : 16'sh7fff, qlayer_pkg::shift_t'(e));
            end else begin
                write_cfg(qlayer_pkg::scale_t'((e % 2) ? -1 : 1), qlayer_pkg::shift_t'(e - 2));
            end
        end
        for (int v = 0; v < 2; v++) begin
            beat_x[0] = (v == 0) ? 8'sh7f : 8'sh80;
            for (int k = 0; k < NE; k++) begin
                beat_w[0][k] = (k < 4) ? ((k >= 2) ? 8'sh80 : 8'sh7f) :
                               qlayer_pkg::wgt_t'($random(seed) % 5);
            end
            send_stream(1, 1'b1);
        end
        wait_drain();
        end_test("saturation and sign", fails_at);

        fails_at = n_fail;
        for (int k = 0; k < NE; k++) begin
            write_cfg(qlayer_pkg::scale_t'($random(seed) % 256),
                      qlayer_pkg::shift_t'(8 + ($random(seed) & 7)));
        end
        repeat (8) begin
            e = ($random(seed) & 15) + 1;
            fill_random(e);
            send_stream(e, 1'b1);
        end
        wait_drain();
        end_test("multi-beat accumulation", fails_at);

        // Two vectors wait in the buffer, then each read gives valid one cycle later.
        fails_at = n_fail;
        rd = 1'b0;
        repeat (2) begin
            fill_random(2);
            send_stream(2, 1'b1);
        end
        next_cycle();
        @(negedge clk);
        check_flag("avail_o", 1'b1, avail);
        for (int k = 0; k < 2; k++) begin
            next_cycle();
            rd = 1'b1;
            @(negedge clk);
            check_flag("y_valid_o", 1'b0, y_valid);
            next_cycle();
            rd = 1'b0;
            @(negedge clk);
            check_flag("y_valid_o", 1'b1, y_valid);
            check_flag("avail_o", (k == 0), avail);
        end
        wait_drain();
        end_test("buffering and order", fails_at);

        // The third vector finds the buffer full and is lost.
        fails_at = n_fail;
        @(negedge clk);
        check_flag("overflow_o", 1'b0, overflow);
        for (int k = 0; k < 3; k++) begin
            fill_random(1);
            send_stream(1, (k < 2));
        end
        next_cycle();
        @(negedge clk);
        check_flag("overflow_o", 1'b1, overflow);
        check_flag("avail_o", 1'b1, avail);
        next_cycle();
        rd = 1'b1;
        wait_drain();
        repeat (5) next_cycle();
        @(negedge clk);
        check_flag("overflow_o", 1'b1, overflow);
        check_flag("avail_o", 1'b0, avail);
        end_test("overflow", fails_at);

        $display("checks passed: %0d, checks failed: %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* qlayer.f */
source/qlayer_pkg.sv
source/scale_cfg_if.sv
source/mac_array.sv
source/wx_buffer.sv
source/output_scaler.sv
source/output_scaler_set.sv
source/qlayer_top.sv
verification/tb_clk_gen.sv
verification/qlayer_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the qlayer testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f qlayer.f --top-module qlayer_tb -o qlayer_sim

./obj_dir/qlayer_sim > sim.log
cat sim.log

if grep -q "Test FAILED" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi

echo "Simulation finished without failures"
